// ==== ntm_top.f ====
ntm_pkg.sv
ntm_memory.sv
ntm_mem_arbiter.sv
ntm_read_head.sv
ntm_write_head.sv
ntm_top.sv
ntm_checker.sv
tb_ntm_top.sv

// ==== Bender.yml ====
package:
  name: ntm_top

sources:
  - ntm_pkg.sv
  - ntm_memory.sv
  - ntm_mem_arbiter.sv
  - ntm_read_head.sv
  - ntm_write_head.sv
  - ntm_top.sv
  - target: test
    files:
      - ntm_checker.sv
      - tb_ntm_top.sv

// ==== ntm_testdata.txt ====
# Each line holds op, idle gap in cycles, w0 w1 w2 w3, then a0 a1 a2 a3 for W and B, words in hex
# op R reads, W writes, B starts both heads in the same cycle with one shared weighting
# Reset leaves M at zero
R 0 0001 0001 0001 0001
R 1 1234 0000 ffff 0007
# One write, read back with the same weighting
W 0 0001 0002 0003 0004 0001 0001 0001 0001
R 0 0001 0002 0003 0004
# Further writes accumulate
W 2 0001 0002 0003 0004 0002 0000 0003 0005
R 1 0001 0001 0001 0001
W 0 0005 0000 0000 0009 0010 0020 0030 0040
R 3 0002 0003 0005 0007
# Large operands wrap in product and sum
W 1 ffff 8000 00ff 1001 ffff 0002 8001 7fff
R 0 ffff ffff ffff ffff
W 0 fffe 7fff 0100 ffff 8000 ffff 00ff 1234
R 2 8000 0003 ffff 0101
# Tie after a read goes to the write
B 0 0003 0001 0004 0001 0005 0009 0002 0006
# Tie after a tie keeps the same order
B 1 0002 0007 0001 0008 0002 0008 0001 0008
R 0 0001 0001 0001 0001
# Tie after a write goes to the read
W 3 0000 0001 0000 0000 0010 0020 0030 0040
B 0 0001 0002 0003 0004 0100 0200 0300 0400
B 2 ffff 0001 8000 0002 7fff 0003 ffff 0004
R 0 0001 0001 0001 0001
# Back to back with short gaps
R 0 0009 0008 0007 0006
W 0 0011 0022 0033 0044 0001 0002 0003 0004
R 0 0011 0022 0033 0044
W 1 abcd 0000 1357 2468 0fed 0001 c001 0003
R 0 0001 0000 0000 0000
R 0 0000 0000 0000 0001

// ==== tb_ntm_top.sv ====
// Testbench top for the NTM memory block, plays the data file through the DUT and the checker
`timescale 1ns/1ns

module tb_ntm_top
  import ntm_pkg::*;
();

  logic        CLK;
  logic        RST;
  logic        read_start;
  ntm_weight_t read_weight;
  logic        read_ready;
  ntm_vec_t    read_vec;
  logic        write_start;
  ntm_weight_t write_weight;
  ntm_vec_t    write_add;
  logic        write_ready;

  int          pass_count;
  int          fail_count;

  // Parsed operations, one entry per data line
  logic [7:0]  op_q [$];
  int          gap_q [$];
  ntm_weight_t w_q [$];
  ntm_vec_t    a_q [$];

  int          fd;
  int          load_errors;
  int          cycle_count;
  int          cycle_limit;
  int unsigned seed_val;

  //////////////////////////////
  // DUT and checker
  //////////////////////////////

  ntm_top i_dut (
    .CLK          (CLK),
    .RST          (RST),
    .read_start   (read_start),
    .read_weight  (read_weight),
    .read_ready   (read_ready),
    .read_vec     (read_vec),
    .write_start  (write_start),
    .write_weight (write_weight),
    .write_add    (write_add),
    .write_ready  (write_ready)
  );

  ntm_checker i_checker (
    .CLK          (CLK),
    .RST          (RST),
    .read_start   (read_start),
    .read_weight  (read_weight),
    .read_ready   (read_ready),
    .read_vec     (read_vec),
    .write_start  (write_start),
    .write_weight (write_weight),
    .write_add    (write_add),
    .write_ready  (write_ready),
    .pass_count   (pass_count),
    .fail_count   (fail_count)
  );

  // 100 ns period
  initial CLK = 1'b0;
  always #50 CLK = ~CLK;

  // Watchdog, limit set once the data file is parsed
  always @(posedge CLK) begin
    if (!RST && (cycle_limit > 0)) begin
      cycle_count++;
      if (cycle_count > cycle_limit) begin
        $display("Timeout after %0d cycles, an operation never signalled ready", cycle_limit);
        $display("Simulation FAILED");
        $finish;
      end
    end
  end

  //////////////////////////////
  // Stimulus
  //////////////////////////////

  // Lines starting with # are comments
  task automatic load_operations(input int fd);
    logic [7:0]       op;
    int               gap;
    int               code;
    logic [8*128-1:0] rest;
    ntm_word_t        f [8];
    ntm_weight_t      w;
    ntm_vec_t         a;
    while (!$feof(fd)) begin
      code = $fscanf(fd, " %c", op);
      if (code != 1) begin
        break;
      end
      if (op == "#") begin
        code = $fgets(rest, fd);
      end else begin
        code = $fscanf(fd, "%d %h %h %h %h", gap, f[0], f[1], f[2], f[3]);
        a = '0;
        if (op != "R") begin
          code += $fscanf(fd, "%h %h %h %h", f[4], f[5], f[6], f[7]);
          a = {f[7], f[6], f[5], f[4]};
        end
        w = {f[3], f[2], f[1], f[0]};
        if (((op == "R") && (code == 5)) || ((op != "R") && (code == 9))) begin
          op_q.push_back(op);
          gap_q.push_back(gap);
          w_q.push_back(w);
          a_q.push_back(a);
        end else begin
          $display("Malformed data line %0d with operation %c", op_q.size() + 1, op);
          load_errors++;
        end
      end
    end
  endtask

  // Starts one line's operation and waits for all its ready pulses
  task automatic run_operation(input logic [7:0] op, input int gap,
                               input ntm_weight_t w, input ntm_vec_t a);
    int   extra;
    logic rd_wait;
    logic wr_wait;
    extra = $urandom % 4;
    repeat (gap + extra) begin
      @(posedge CLK);
      #10;
    end
    if ((op == "R") || (op == "B")) begin
      read_weight = w;
      read_start  = 1'b1;
    end
    if ((op == "W") || (op == "B")) begin
      write_weight = w;
      write_add    = a;
      write_start  = 1'b1;
    end
    @(posedge CLK);
    #10;
    read_start  = 1'b0;
    write_start = 1'b0;
    rd_wait = (op != "W");
    wr_wait = (op != "R");
    while (rd_wait || wr_wait) begin
      @(posedge CLK);
      #10;
      if (read_ready) begin
        rd_wait = 1'b0;
      end
      if (write_ready) begin
        wr_wait = 1'b0;
      end
    end
  endtask

  initial begin
    RST          = 1'b1;
    read_start   = 1'b0;
    read_weight  = '0;
    write_start  = 1'b0;
    write_weight = '0;
    write_add    = '0;
    load_errors  = 0;
    cycle_count  = 0;
    cycle_limit  = 0;
    seed_val     = $urandom(32'hdcf8);

    fd = $fopen("ntm_testdata.txt", "r");
    if (fd == 0) begin
      $display("Could not open ntm_testdata.txt for reading");
      load_errors++;
    end else begin
      load_operations(fd);
      $fclose(fd);
    end
    // Worst case per line, both operations plus gaps
    cycle_limit = op_q.size() * (2 * ntm_elems + ntm_elems + 10 + 3);

    repeat (16) @(posedge CLK);
    #10;
    RST = 1'b0;

    foreach (op_q[i]) begin
      run_operation(op_q[i], gap_q[i], w_q[i], a_q[i]);
    end
    // A few idle cycles to catch stray ready pulses
    repeat (5) @(posedge CLK);
    #10;

    $display("Summary %0d tests passed, %0d tests failed, %0d load errors",
             pass_count, fail_count, load_errors);
    if ((fail_count == 0) && (load_errors == 0) && (pass_count > 0)) begin
      $display("Simulation PASSED");
    end else begin
      $display("Simulation FAILED");
    end
    $finish;
  end

endmodule

// ==== ntm_checker.sv ====
// Testbench checker with a reference model of M that predicts each read and reports every test
`timescale 1ns/1ns

module ntm_checker
  import ntm_pkg::*;
(
  input  logic        CLK,
  input  logic        RST,

  // DUT ports, observed only
  input  logic        read_start,
  input  ntm_weight_t read_weight,
  input  logic        read_ready,
  input  ntm_vec_t    read_vec,
  input  logic        write_start,
  input  ntm_weight_t write_weight,
  input  ntm_vec_t    write_add,
  input  logic        write_ready,

  // Test tallies
  output int          pass_count,
  output int          fail_count
);

  // Reference copy of M, row-major
  ntm_word_t   model [ntm_elems];

  // Operands captured at each start
  ntm_weight_t rd_weight;
  ntm_weight_t wr_weight;
  ntm_vec_t    wr_add;
  logic        rd_pending;
  logic        wr_pending;

  // Head served last, read after reset so the write wins the first tie
  logic        last_was_read;
  // Simultaneous starts waiting for their first ready
  logic        order_open;
  logic        write_first;

  // Read result that must stay put between reads
  ntm_vec_t    held_vec;
  logic        held_valid;

  int          test_num;
  logic        test_ok;
  ntm_vec_t    expected;

  //////////////////////////////
  // Reference model
  //////////////////////////////

  // r(k) as the wrapped sum of w(j)*M(j,k)
  function automatic ntm_vec_t predict_read(ntm_weight_t w);
    ntm_vec_t  r;
    ntm_word_t p;
    r = '0;
    for (int j = 0; j < ntm_rows; j++) begin
      for (int k = 0; k < ntm_cols; k++) begin
        // Only the low 16 bits of the product survive
        p    = w[j] * model[j * ntm_cols + k];
        r[k] = r[k] + p;
      end
    end
    return r;
  endfunction

  // M(j,k) grows by w(j)*a(k), wrapped
  task automatic apply_write(input ntm_weight_t w, input ntm_vec_t a);
    ntm_word_t p;
    for (int j = 0; j < ntm_rows; j++) begin
      for (int k = 0; k < ntm_cols; k++) begin
        p = w[j] * a[k];
        model[j * ntm_cols + k] = model[j * ntm_cols + k] + p;
      end
    end
  endtask

  task automatic report_test(input string kind, input logic ok);
    test_num++;
    if (ok) begin
      pass_count++;
    end else begin
      fail_count++;
    end
    $display("Test %0d %s at %0t %s", test_num, kind, $time, ok ? "passed" : "failed");
  endtask

  initial begin
    pass_count = 0;
    fail_count = 0;
    test_num   = 0;
  end

  //////////////////////////////
  // Monitor
  //////////////////////////////

  // Mid-cycle sampling, inputs and outputs are settled here
  always @(negedge CLK) begin
    if (RST) begin
      for (int i = 0; i < ntm_elems; i++) begin
        model[i] = '0;
      end
      rd_pending    = 1'b0;
      wr_pending    = 1'b0;
      last_was_read = 1'b1;
      order_open    = 1'b0;
      held_valid    = 1'b0;
    end else begin
      // read_vec frozen between reads
      if (held_valid && (read_vec !== held_vec)) begin
        $display("** Error @%0t: read_vec moved from %h to %h with no read running",
                 $time, held_vec, read_vec);
        fail_count++;
        held_vec = read_vec;
      end

      // Write lands in the model before any read of the same cycle
      if (write_ready) begin
        test_ok = 1'b1;
        if (!wr_pending) begin
          $display("write_ready at %0t came without a pending write_start", $time);
          test_ok = 1'b0;
        end else begin
          apply_write(wr_weight, wr_add);
        end
        if (order_open) begin
          order_open = 1'b0;
          if (!write_first) begin
            $display("Write finished first at %0t although the read should win the tie",
                     $time);
            test_ok = 1'b0;
          end
        end
        wr_pending = 1'b0;
        report_test("write", test_ok);
      end

      if (read_ready) begin
        test_ok = 1'b1;
        if (!rd_pending) begin
          $display("read_ready at %0t came without a pending read_start", $time);
          test_ok = 1'b0;
        end else begin
          expected = predict_read(rd_weight);
          for (int k = 0; k < ntm_cols; k++) begin
            if (read_vec[k] !== expected[k]) begin
              $display("** Error @%0t: r(%0d) is %h, expected %h",
                       $time, k, read_vec[k], expected[k]);
              test_ok = 1'b0;
            end
          end
        end
        if (order_open) begin
          order_open = 1'b0;
          if (write_first) begin
            $display("Read finished first at %0t although the write should win the tie",
                     $time);
            test_ok = 1'b0;
          end
        end
        rd_pending = 1'b0;
        held_vec   = read_vec;
        held_valid = 1'b1;
        report_test("read", test_ok);
      end

      // Arbitration order from the round-robin rule
      if (read_start && write_start) begin
        order_open  = 1'b1;
        write_first = last_was_read;
        // Loser goes last, so the last served head stays the same
      end else if (read_start) begin
        last_was_read = 1'b1;
      end else if (write_start) begin
        last_was_read = 1'b0;
      end

      if (read_start) begin
        if (rd_pending) begin
          $display("read_start at %0t while the previous read had no read_ready", $time);
          fail_count++;
        end
        rd_pending = 1'b1;
        rd_weight  = read_weight;
        held_valid = 1'b0;
      end

      if (write_start) begin
        if (wr_pending) begin
          $display("write_start at %0t while the previous write had no write_ready", $time);
          fail_count++;
        end
        wr_pending = 1'b1;
        wr_weight  = write_weight;
        wr_add     = write_add;
      end
    end
  end

endmodule

// ==== ntm_top.sv ====
// Top level of the NTM memory block with both heads sharing M through the arbiter
`timescale 1ns/1ns

module ntm_top
  import ntm_pkg::*;
(
  input  logic        CLK,
  input  logic        RST,

  // Read operation
  input  logic        read_start,
  input  ntm_weight_t read_weight,
  output logic        read_ready,
  output ntm_vec_t    read_vec,

  // Write operation
  input  logic        write_start,
  input  ntm_weight_t write_weight,
  input  ntm_vec_t    write_add,
  output logic        write_ready
);

  // Head side of the arbiter
  ntm_mem_req_t rd_req;
  ntm_mem_req_t wr_req;
  logic         rd_gnt;
  logic         wr_gnt;

  // Memory side of the arbiter
  ntm_mem_req_t mem_req;
  ntm_word_t    mem_rdata;

  ntm_read_head i_read_head (
    .CLK         (CLK),
    .RST         (RST),
    .read_start  (read_start),
    .read_weight (read_weight),
    .read_ready  (read_ready),
    .read_vec    (read_vec),
    .rd_req      (rd_req),
    .rd_gnt      (rd_gnt),
    .mem_rdata   (mem_rdata)
  );

  ntm_write_head i_write_head (
    .CLK          (CLK),
    .RST          (RST),
    .write_start  (write_start),
    .write_weight (write_weight),
    .write_add    (write_add),
    .write_ready  (write_ready),
    .wr_req       (wr_req),
    .wr_gnt       (wr_gnt),
    .mem_rdata    (mem_rdata)
  );

  ntm_mem_arbiter i_mem_arbiter (
    .CLK     (CLK),
    .RST     (RST),
    .rd_req  (rd_req),
    .wr_req  (wr_req),
    .rd_gnt  (rd_gnt),
    .wr_gnt  (wr_gnt),
    .mem_req (mem_req)
  );

  // Shared read data, only the owner samples it
  ntm_memory i_memory (
    .CLK       (CLK),
    .RST       (RST),
    .mem_req   (mem_req),
    .mem_rdata (mem_rdata)
  );

endmodule

// ==== ntm_write_head.sv ====
// Write head that updates every element as M(j,k) + w(j)*a(k) by read-modify-write
`timescale 1ns/1ns

module ntm_write_head
  import ntm_pkg::*;
(
  input  logic         CLK,
  input  logic         RST,

  // Operation strobes and data
  input  logic         write_start,
  input  ntm_weight_t  write_weight,
  input  ntm_vec_t     write_add,
  output logic         write_ready,

  // Memory port through the arbiter
  output ntm_mem_req_t wr_req,
  input  logic         wr_gnt,
  input  ntm_word_t    mem_rdata
);

  typedef enum logic [1:0] {
    st_idle,
    st_read,
    st_write
  } wr_state_t;

  wr_state_t             state_q;
  // Element under update
  logic [ntm_addr_w-1:0] addr_q;

  // Captured operands
  ntm_weight_t           weight_q;
  ntm_vec_t              add_q;

  logic [ntm_addr_w-ntm_col_w-1:0] row;
  logic [ntm_col_w-1:0]            col;
  ntm_word_t                       product;
  ntm_word_t                       sum;

  //////////////////////////////
  // Control FSM
  //////////////////////////////

  always_ff @(posedge CLK or posedge RST) begin
    if (RST) begin
      state_q     <= st_idle;
      addr_q      <= '0;
      write_ready <= 1'b0;
    end else begin
      write_ready <= 1'b0;
      case (state_q)
        st_idle: begin
          if (write_start) begin
            addr_q  <= '0;
            state_q <= st_read;
          end
        end
        st_read: begin
          // Fetch the old word
          if (wr_gnt) begin
            state_q <= st_write;
          end
        end
        st_write: begin
          // Store the updated word, then next element or done
          if (wr_gnt) begin
            if (addr_q == ntm_addr_w'(ntm_elems - 1)) begin
              write_ready <= 1'b1;
              state_q     <= st_idle;
            end else begin
              addr_q  <= addr_q + 1'b1;
              state_q <= st_read;
            end
          end
        end
        default: begin
          state_q <= st_idle;
        end
      endcase
    end
  end

  // w and a latched once per operation
  always_ff @(posedge CLK) begin
    if (write_start && (state_q == st_idle)) begin
      weight_q <= write_weight;
      add_q    <= write_add;
    end
  end

  //////////////////////////////
  // Update datapath
  //////////////////////////////

  assign row     = addr_q[ntm_addr_w-1:ntm_col_w];
  assign col     = addr_q[ntm_col_w-1:0];
  // Both product and sum wrap at 16 bits
  assign product = ntm_word_t'(weight_q[row] * add_q[col]);
  // mem_rdata holds the word fetched in the read phase
  assign sum     = mem_rdata + product;

  assign wr_req.req   = (state_q != st_idle);
  assign wr_req.we    = (state_q == st_write);
  assign wr_req.addr  = addr_q;
  assign wr_req.wdata = sum;

  a_start_when_idle: assert property (
    @(posedge CLK) disable iff (RST)
    write_start |-> (state_q == st_idle)
  );

endmodule

// ==== ntm_read_head.sv ====
// Read head that streams M row by row and accumulates r(k) as the sum of w(j)*M(j,k)
`timescale 1ns/1ns

module ntm_read_head
  import ntm_pkg::*;
(
  input  logic         CLK,
  input  logic         RST,

  // Operation strobes and data
  input  logic         read_start,
  input  ntm_weight_t  read_weight,
  output logic         read_ready,
  output ntm_vec_t     read_vec,

  // Memory port through the arbiter
  output ntm_mem_req_t rd_req,
  input  logic         rd_gnt,
  input  ntm_word_t    mem_rdata
);

  typedef enum logic [1:0] {
    st_idle,
    st_stream,
    st_drain
  } rd_state_t;

  rd_state_t             state_q;
  // Next address to issue
  logic [ntm_addr_w-1:0] issue_addr_q;
  // Read issued in the previous cycle, and its address
  logic                  issue_d_q;
  logic [ntm_addr_w-1:0] addr_d_q;

  // Captured weighting and running sums
  ntm_weight_t           weight_q;
  ntm_vec_t              acc_q;

  // Returning word position
  logic [ntm_addr_w-ntm_col_w-1:0] row_d;
  logic [ntm_col_w-1:0]            col_d;
  ntm_word_t                       product;

  //////////////////////////////
  // Control FSM
  //////////////////////////////

  always_ff @(posedge CLK or posedge RST) begin
    if (RST) begin
      state_q      <= st_idle;
      issue_addr_q <= '0;
      issue_d_q    <= 1'b0;
      read_ready   <= 1'b0;
    end else begin
      read_ready <= 1'b0;
      issue_d_q  <= (state_q == st_stream) && rd_gnt;
      case (state_q)
        st_idle: begin
          if (read_start) begin
            issue_addr_q <= '0;
            state_q      <= st_stream;
          end
        end
        st_stream: begin
          // One read per granted cycle, row-major
          if (rd_gnt) begin
            issue_addr_q <= issue_addr_q + 1'b1;
            if (issue_addr_q == ntm_addr_w'(ntm_elems - 1)) begin
              state_q <= st_drain;
            end
          end
        end
        st_drain: begin
          // Last word is summed this cycle
          read_ready <= 1'b1;
          state_q    <= st_idle;
        end
        default: begin
          state_q <= st_idle;
        end
      endcase
    end
  end

  //////////////////////////////
  // Accumulation
  //////////////////////////////

  assign row_d   = addr_d_q[ntm_addr_w-1:ntm_col_w];
  assign col_d   = addr_d_q[ntm_col_w-1:0];
  // Low 16 bits of w(j)*M(j,k)
  assign product = ntm_word_t'(weight_q[row_d] * mem_rdata);

  always_ff @(posedge CLK) begin
    addr_d_q <= issue_addr_q;
    if (read_start && (state_q == st_idle)) begin
      weight_q <= read_weight;
      acc_q    <= '0;
    end else if (issue_d_q) begin
      acc_q[col_d] <= acc_q[col_d] + product;
    end
  end

  // Sums stay put from read_ready until the next start
  assign read_vec = acc_q;

  // Reads only, request held through the last issue
  assign rd_req.req   = (state_q == st_stream);
  assign rd_req.we    = 1'b0;
  assign rd_req.addr  = issue_addr_q;
  assign rd_req.wdata = '0;

  a_start_when_idle: assert property (
    @(posedge CLK) disable iff (RST)
    read_start |-> (state_q == st_idle)
  );

endmodule

// ==== ntm_mem_arbiter.sv ====
// Round-robin arbiter that hands the memory port to one head for a whole operation
`timescale 1ns/1ns

module ntm_mem_arbiter
  import ntm_pkg::*;
(
  input  logic         CLK,
  input  logic         RST,

  // Head requests
  input  ntm_mem_req_t rd_req,
  input  ntm_mem_req_t wr_req,

  // Grant levels back to the heads
  output logic         rd_gnt,
  output logic         wr_gnt,

  // Owner's request toward the memory
  output ntm_mem_req_t mem_req
);

  // Port held by a head in the previous cycle
  logic       busy_q;
  // Current owner while busy, last served head while free
  ntm_owner_t owner_q;

  //////////////////////////////
  // Grant decision
  //////////////////////////////

  always_comb begin
    rd_gnt = 1'b0;
    wr_gnt = 1'b0;
    if (busy_q && (owner_q == owner_read) && rd_req.req) begin
      // Read head keeps the port until its req drops
      rd_gnt = 1'b1;
    end else if (busy_q && (owner_q == owner_write) && wr_req.req) begin
      wr_gnt = 1'b1;
    end else if (rd_req.req && wr_req.req) begin
      // Tie goes to the head not served last
      if (owner_q == owner_read) begin
        wr_gnt = 1'b1;
      end else begin
        rd_gnt = 1'b1;
      end
    end else begin
      // At most one requester left
      rd_gnt = rd_req.req;
      wr_gnt = wr_req.req;
    end
  end

  // Owner state
  // Reset value read lets the write head win the first tie
  always_ff @(posedge CLK or posedge RST) begin
    if (RST) begin
      busy_q  <= 1'b0;
      owner_q <= owner_read;
    end else begin
      busy_q <= rd_gnt | wr_gnt;
      if (rd_gnt) begin
        owner_q <= owner_read;
      end else if (wr_gnt) begin
        owner_q <= owner_write;
      end
    end
  end

  // Forward the owner's request, all zero when the port is free
  always_comb begin
    mem_req = '0;
    if (wr_gnt) begin
      mem_req = wr_req;
    end else if (rd_gnt) begin
      mem_req = rd_req;
    end
  end

  //////////////////////////////
  // Checks
  //////////////////////////////

  a_gnt_onehot: assert property (
    @(posedge CLK) disable iff (RST)
    !(rd_gnt && wr_gnt)
  );

  // Operation stays atomic once granted
  a_rd_gnt_held: assert property (
    @(posedge CLK) disable iff (RST)
    (rd_gnt && rd_req.req) |=> (rd_gnt || !rd_req.req)
  );

  a_wr_gnt_held: assert property (
    @(posedge CLK) disable iff (RST)
    (wr_gnt && wr_req.req) |=> (wr_gnt || !wr_req.req)
  );

endmodule

// ==== ntm_memory.sv ====
// Single-port memory matrix M, cleared on reset, read data one cycle after the request
`timescale 1ns/1ns

module ntm_memory
  import ntm_pkg::*;
(
  input  logic         CLK,
  input  logic         RST,

  // Request already selected by the arbiter
  input  ntm_mem_req_t mem_req,
  output ntm_word_t    mem_rdata
);

  //////////////////////////////
  // Storage
  //////////////////////////////

  // Row-major element array with M(j,k) at j*W+k
  ntm_word_t mem_q [ntm_elems];

  // Write port
  // Whole matrix back to zero on reset
  always_ff @(posedge CLK or posedge RST) begin
    if (RST) begin
      for (int i = 0; i < ntm_elems; i++) begin
        mem_q[i] <= '0;
      end
    end else if (mem_req.req && mem_req.we) begin
      mem_q[mem_req.addr] <= mem_req.wdata;
    end
  end

  // Read port
  // Word appears on mem_rdata in the cycle after the read
  // Holds its value until the next read
  always_ff @(posedge CLK) begin
    if (mem_req.req && !mem_req.we) begin
      mem_rdata <= mem_q[mem_req.addr];
    end
  end

  //////////////////////////////
  // Checks
  //////////////////////////////

  // Any active access must be fully defined and land inside the matrix
  a_addr_in_range: assert property (
    @(posedge CLK) disable iff (RST)
    mem_req.req |-> (!$isunknown({mem_req.we, mem_req.addr}) &&
                     (mem_req.addr < ntm_elems))
  );

endmodule

// ==== ntm_pkg.sv ====
// Shared sizes, word and vector types and the memory request struct for the NTM memory block
package ntm_pkg;

  //////////////////////////////
  // Sizes
  //////////////////////////////

  // Number of memory rows N (index j)
  localparam int ntm_rows   = 4;
  // Number of memory columns W (index k)
  localparam int ntm_cols   = 4;
  // Word width of one matrix element
  localparam int ntm_word_w = 16;
  // Flat element address j*W+k
  localparam int ntm_addr_w = 4;

  // Total element count N*W
  localparam int ntm_elems  = ntm_rows * ntm_cols;
  // Low address bits select the column, W is a power of two
  localparam int ntm_col_w  = $clog2(ntm_cols);

  //////////////////////////////
  // Data types
  //////////////////////////////

  // One unsigned word, all arithmetic wraps at this width
  typedef logic [ntm_word_w-1:0] ntm_word_t;

  // Weighting w(j), one word per row
  typedef ntm_word_t [ntm_rows-1:0] ntm_weight_t;

  // Add vector a(k) and read vector r(k), one word per column
  typedef ntm_word_t [ntm_cols-1:0] ntm_vec_t;

  // Request from a head toward the memory port
  typedef struct packed {
    logic                  req;
    logic                  we;
    logic [ntm_addr_w-1:0] addr;
    ntm_word_t             wdata;
  } ntm_mem_req_t;

  // Head that currently owns, or last owned, the memory port
  typedef enum logic {
    owner_write = 1'b0,
    owner_read  = 1'b1
  } ntm_owner_t;

endpackage
